// ==== adc_frontend_top.f ====
source/adc_frontend_pkg.sv
source/adc_lane_capture.sv
source/clock_health_monitor.sv
source/adc_frontend_top.sv
tests/adc_frontend_checker.sv
tests/tb_adc_frontend.sv

// ==== Makefile ====
TOP = tb_adc_frontend

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  make test   build with Verilator, run the testbench, check the log"
	@echo "  make clean  remove build output and the log"
	@echo "  make help   this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
	  -f adc_frontend_top.f -o V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Result: FAILED" sim.log; then \
	  echo "simulation reported failure"; \
	  exit 1; \
	fi
	@grep -q "Result: PASSED" sim.log || { echo "no result line in sim.log"; exit 1; }
	@echo "simulation ok"

clean:
	rm -rf obj_dir sim.log

// ==== tests/tb_adc_frontend.sv ====
`timescale 1ns/1ps

// testbench top: clock, reset, lfsr stimulus, test order

module tb_adc_frontend import adc_frontend_pkg::*; ();

  localparam int clk_period      = 40; // ns
  localparam int reset_cycles    = 5;
  localparam int tb_blink_period = 40; // short heartbeat for simulation

  logic                                           clk_125_0 = 1'b0;
  logic                                           rstn_125_0;
  logic [num_channels-1:0][pins_per_channel-1:0] adc_fall_i;
  logic [num_channels-1:0][pins_per_channel-1:0] adc_rise_i;
  logic [num_plls-1:0]                            pll_locked_i;
  adc_sample_t [num_channels-1:0]                 adc_dat_o;
  logic [diag_width-1:0]                          lock_loss_cnt_o;
  logic [led_width-1:0]                           led_o;

  int          test_num;
  logic        finish_req;
  int          err_total;
  logic        timed_out;
  logic [31:0] lfsr_state;

  always #(clk_period / 2) clk_125_0 = ~clk_125_0;

  adc_frontend_top #(
    .blink_period_cycles (tb_blink_period)
  ) DUT (
    .clk_125_0       (clk_125_0),
    .rstn_125_0      (rstn_125_0),
    .adc_fall_i      (adc_fall_i),
    .adc_rise_i      (adc_rise_i),
    .pll_locked_i    (pll_locked_i),
    .adc_dat_o       (adc_dat_o),
    .lock_loss_cnt_o (lock_loss_cnt_o),
    .led_o           (led_o)
  );

  adc_frontend_checker #(
    .blink_period_cycles (tb_blink_period)
  ) u_checker (
    .clk_125_0       (clk_125_0),
    .rstn_125_0      (rstn_125_0),
    .adc_fall_i      (adc_fall_i),
    .adc_rise_i      (adc_rise_i),
    .pll_locked_i    (pll_locked_i),
    .adc_dat_i       (adc_dat_o),
    .lock_loss_cnt_i (lock_loss_cnt_o),
    .led_i           (led_o),
    .test_num_i      (test_num),
    .finish_i        (finish_req),
    .err_total_o     (err_total)
  );

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // galois lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic drive_random_pins();
    logic [num_channels-1:0][pins_per_channel-1:0] fall_v;
    logic [num_channels-1:0][pins_per_channel-1:0] rise_v;
    logic [31:0]                                    bits;
    for (int ch = 0; ch < num_channels; ch++) begin
      draw_bits(pins_per_channel, bits);
      fall_v[ch] = bits[pins_per_channel-1:0];
      draw_bits(pins_per_channel, bits);
      rise_v[ch] = bits[pins_per_channel-1:0];
    end
    adc_fall_i <= fall_v;
    adc_rise_i <= rise_v;
  endtask

  // caller sits on a rising edge
  task automatic apply_reset();
    rstn_125_0 <= 1'b0;
    for (int i = 0; i < reset_cycles; i++) @(posedge clk_125_0);
    rstn_125_0 <= 1'b1;
  endtask

  // heartbeat led must flip within max_cycles, sampled mid-cycle
  task automatic wait_led_toggle(input int max_cycles);
    logic start;
    logic seen;
    int   n;
    start = led_o[0];
    seen  = 1'b0;
    n     = 0;
    while (!seen && n < max_cycles) begin
      @(negedge clk_125_0);
      n++;
      if (led_o[0] != start) seen = 1'b1;
    end
    if (!seen) begin
      $display("timeout: heartbeat led did not toggle within %0d cycles", max_cycles);
      timed_out = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test order
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [num_channels-1:0][pins_per_channel-1:0] fall_v;
    logic [num_channels-1:0][pins_per_channel-1:0] rise_v;
    logic [31:0]                                    bits;
    rstn_125_0   = 1'b0;
    adc_fall_i   = '0;
    adc_rise_i   = '0;
    pll_locked_i = '1;
    test_num     = 1;
    finish_req   = 1'b0;
    timed_out    = 1'b0;
    lfsr_state   = 32'hb316_4c1e;

    // 1: reset levels, then release with quiet pins
    @(posedge clk_125_0);
    apply_reset();
    repeat (6) @(posedge clk_125_0);

    // 2: random pins on every channel
    test_num <= 2;
    for (int i = 0; i < 500; i++) begin
      drive_random_pins();
      @(posedge clk_125_0);
    end

    // 3: single one walked through every raw bit of every lane
    test_num <= 3;
    for (int ch = 0; ch < num_channels; ch++) begin
      for (int b = 0; b < sample_width; b++) begin
        fall_v = '0;
        rise_v = '0;
        if (b % 2 == 0) fall_v[ch][b/2] = 1'b1; // even raw bit
        else            rise_v[ch][b/2] = 1'b1; // odd raw bit
        adc_fall_i <= fall_v;
        adc_rise_i <= rise_v;
        @(posedge clk_125_0);
      end
    end

    // 4: fresh reset, then three heartbeat toggles
    test_num <= 4;
    apply_reset();
    for (int t = 0; t < 3; t++) wait_led_toggle(tb_blink_period + 20);
    @(posedge clk_125_0);

    // 5: random lock flags, each low about a quarter of the time
    test_num <= 5;
    for (int i = 0; i < 300; i++) begin
      draw_bits(4, bits);
      pll_locked_i <= {~&bits[3:2], ~&bits[1:0]};
      drive_random_pins();
      @(posedge clk_125_0);
    end
    pll_locked_i <= '1; // counter has to settle and hold
    repeat (20) @(posedge clk_125_0);

    test_num <= 0;
    repeat (2) @(posedge clk_125_0);
    finish_req <= 1'b1;
    @(negedge clk_125_0);
    if (err_total == 0 && !timed_out) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/adc_frontend_checker.sv ====
`timescale 1ns/1ps

// watches the front end ports and compares against its own model on every falling edge

module adc_frontend_checker import adc_frontend_pkg::*; #(
  parameter int blink_period_cycles = 40 // must match the dut
)(
  input  logic                                           clk_125_0,
  input  logic                                           rstn_125_0,
  input  logic [num_channels-1:0][pins_per_channel-1:0] adc_fall_i,
  input  logic [num_channels-1:0][pins_per_channel-1:0] adc_rise_i,
  input  logic [num_plls-1:0]                            pll_locked_i,
  input  adc_sample_t [num_channels-1:0]                 adc_dat_i,       // dut samples
  input  logic [diag_width-1:0]                          lock_loss_cnt_i, // dut counter
  input  logic [led_width-1:0]                           led_i,           // dut leds
  input  int                                             test_num_i,      // 0 = idle
  input  logic                                           finish_i,        // closing line
  output int                                             err_total_o
);

  localparam int max_fail_lines = 8; // fail lines printed per test

  ////////////////////////////////////////////////////////////////////////////
  // reference model stepped on the rising edge
  ////////////////////////////////////////////////////////////////////////////

  adc_sample_t           exp_d1 [num_channels]; // sample one edge old
  adc_sample_t           exp_d2 [num_channels]; // two edges old as the dut shows it
  logic                  lost_d1;               // any flag low one edge back
  logic                  lost_d2;
  logic [diag_width-1:0] exp_cnt;
  int                    edges_up;              // edges since reset release
  logic                  seen_reset = 1'b0;     // model valid once reset was seen

  int cur_test    = 0;
  int tests_run   = 0;
  int checks      = 0;
  int test_checks = 0;
  int test_errs   = 0;
  int err_count   = 0;

  assign err_total_o = err_count;

  // raw code from the pins with the msb kept and the rest flipped
  function automatic adc_sample_t expected_sample(
    input logic [pins_per_channel-1:0] fall,
    input logic [pins_per_channel-1:0] rise
  );
    logic [sample_width-1:0] raw;
    raw = '0;
    for (int k = 0; k < pins_per_channel; k++) begin
      raw = raw | (sample_width'(fall[k]) << (2 * k));     // even slot
      raw = raw | (sample_width'(rise[k]) << (2 * k + 1)); // odd slot
    end
    return adc_sample_t'(raw ^ {1'b0, {(sample_width-1){1'b1}}});
  endfunction

  function automatic string test_name(input int n);
    case (n)
      1:       return "reset state";
      2:       return "conversion";
      3:       return "interleave order";
      4:       return "heartbeat";
      5:       return "lock-loss counting";
      default: return "unknown";
    endcase
  endfunction

  always @(posedge clk_125_0) begin
    seen_reset <= seen_reset | ~rstn_125_0;
    if (!rstn_125_0) begin
      for (int ch = 0; ch < num_channels; ch++) begin
        exp_d1[ch] <= '0;
        exp_d2[ch] <= '0;
      end
      lost_d1  <= 1'b0;
      lost_d2  <= 1'b0;
      exp_cnt  <= '0;
      edges_up <= 0;
    end else begin
      for (int ch = 0; ch < num_channels; ch++) begin
        exp_d1[ch] <= expected_sample(adc_fall_i[ch], adc_rise_i[ch]);
        exp_d2[ch] <= exp_d1[ch];
      end
      lost_d1 <= (pll_locked_i != '1);
      lost_d2 <= lost_d1;                         // two flop delay as in the sync
      if (lost_d2) exp_cnt <= exp_cnt + diag_width'(1);
      edges_up <= edges_up + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // comparisons, per-test lines, summary
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    test_checks++;
    if (got !== exp) begin
      test_errs++;
      err_count++;
      if (test_errs <= max_fail_lines) begin
        $display("FAIL t=%0t %s: got %0h, expected %0h", $time, what, got, exp);
      end
    end
  endtask

  task automatic report_test();
    $display("test %0d %s: %0d checks, %0d errors, %s", cur_test, test_name(cur_test),
             test_checks, test_errs, (test_errs == 0) ? "ok" : "bad");
  endtask

  always @(negedge clk_125_0) begin
    logic                 exp_blink;
    logic [led_width-1:0] exp_led;
    if (test_num_i != cur_test) begin // test boundary
      if (cur_test != 0) report_test();
      cur_test    = test_num_i;
      test_checks = 0;
      test_errs   = 0;
      if (test_num_i != 0) tests_run++;
    end
    if (seen_reset && !finish_i) begin
      exp_blink  = ((edges_up / blink_period_cycles) % 2) == 1; // toggles each period
      exp_led    = '0;
      exp_led[0] = exp_blink;
      exp_led[1] = ~rstn_125_0; // combinational reset led
      exp_led[2] = exp_blink;
      for (int ch = 0; ch < num_channels; ch++) begin
        check_value($sformatf("adc_dat_o[%0d]", ch), 64'(adc_dat_i[ch]), 64'(exp_d2[ch]));
      end
      check_value("lock_loss_cnt_o", 64'(lock_loss_cnt_i), 64'(exp_cnt));
      check_value("led_o", 64'(led_i), 64'(exp_led));
    end
  end

  always @(posedge finish_i) begin
    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, err_count);
  end

endmodule

// ==== source/adc_frontend_top.sv ====
`timescale 1ns/1ps

// fast adc front end, single clock
// four capture lanes side by side with the clock health monitor
// top combines blink and reset into the board led word

module adc_frontend_top import adc_frontend_pkg::*; #(
  parameter int blink_period_cycles = default_blink_period // heartbeat half period
)(
  input  logic                                             clk_125_0,
  input  logic                                             rstn_125_0,
  // adc ddr pins already split per edge
  input  logic [num_channels-1:0][pins_per_channel-1:0]   adc_fall_i,
  input  logic [num_channels-1:0][pins_per_channel-1:0]   adc_rise_i,
  // pll status
  input  logic [num_plls-1:0]                              pll_locked_i,
  // converted samples, one per channel
  output adc_sample_t [num_channels-1:0]                   adc_dat_o,
  // diagnostics
  output logic [diag_width-1:0]                            lock_loss_cnt_o,
  output logic [led_width-1:0]                             led_o
);

  ////////////////////////////////////////////////////////////////////////////
  // capture lanes
  ////////////////////////////////////////////////////////////////////////////

  // one identical lane per channel on its own pin slices
  for (genvar ch = 0; ch < num_channels; ch++) begin : g_lane
    adc_lane_capture u_lane (
      .clk_125_0  (clk_125_0),
      .rstn_125_0 (rstn_125_0),
      .adc_fall_i (adc_fall_i[ch]),  // even raw bits
      .adc_rise_i (adc_rise_i[ch]),  // odd raw bits
      .adc_dat_o  (adc_dat_o[ch])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // clock health
  ////////////////////////////////////////////////////////////////////////////

  logic blink; // heartbeat shared by both led bits

  clock_health_monitor #(
    .blink_period_cycles (blink_period_cycles)
  ) u_monitor (
    .clk_125_0       (clk_125_0),
    .rstn_125_0      (rstn_125_0),
    .pll_locked_i    (pll_locked_i),
    .blink_o         (blink),
    .lock_loss_cnt_o (lock_loss_cnt_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // led word
  ////////////////////////////////////////////////////////////////////////////

  // bit 0  heartbeat
  // bit 1  reset active straight from the pin with no flop
  // bit 2  heartbeat again on the second board led
  // upper bits unused and tied low
  assign led_o = {{(led_width-3){1'b0}}, // spare leds off
                  blink,                 // led 2
                  ~rstn_125_0,           // led 1 lit while in reset
                  blink};                // led 0

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // every lane reads zero right after a reset edge
  a_lanes_clear: assert property (
    @(posedge clk_125_0)
    ($past(rstn_125_0) == 1'b0) |-> (adc_dat_o == '0)
  ) else $error("top: samples not cleared by reset");

endmodule

// ==== source/clock_health_monitor.sv ====
`timescale 1ns/1ps

// clock and pll health
// heartbeat blinker so the board shows it has a running clock
// lock flags through a 2-flop synchronizer, then a lock-loss cycle counter

module clock_health_monitor import adc_frontend_pkg::*; #(
  parameter int blink_period_cycles = default_blink_period // cycles per toggle
)(
  input  logic                  clk_125_0,       // system clock
  input  logic                  rstn_125_0,      // sync, active low
  input  logic [num_plls-1:0]   pll_locked_i,    // async lock flags
  output logic                  blink_o,         // heartbeat
  output logic [diag_width-1:0] lock_loss_cnt_o  // cycles with any pll unlocked
);

  ////////////////////////////////////////////////////////////////////////////
  // heartbeat
  ////////////////////////////////////////////////////////////////////////////

  // enough bits to reach blink_period_cycles-1
  localparam int hb_width = (blink_period_cycles > 1) ? $clog2(blink_period_cycles) : 1;
  localparam logic [hb_width-1:0] hb_last = hb_width'(blink_period_cycles - 1);

  logic [hb_width-1:0] hb_cnt;    // 0 .. period-1
  logic                hb_wrap;   // counter sits on its last value

  assign hb_wrap = (hb_cnt == hb_last);

  always_ff @(posedge clk_125_0) begin
    if (!rstn_125_0) begin
      hb_cnt  <= '0;
      blink_o <= 1'b0;
    end else if (hb_wrap) begin
      hb_cnt  <= '0;
      blink_o <= ~blink_o; // toggle on the same edge as the wrap
    end else begin
      hb_cnt  <= hb_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // lock flag synchronizer
  ////////////////////////////////////////////////////////////////////////////

  logic [num_plls-1:0] lock_meta_q; // first flop that may go metastable
  logic [num_plls-1:0] lock_sync_q; // second flop is safe to use
  logic                lock_lost;   // any pll reports unlocked

  // both flops start at all ones, which reads as locked
  always_ff @(posedge clk_125_0) begin
    if (!rstn_125_0) begin
      lock_meta_q <= '1;
      lock_sync_q <= '1;
    end else begin
      lock_meta_q <= pll_locked_i;
      lock_sync_q <= lock_meta_q;
    end
  end

  assign lock_lost = ~&lock_sync_q;

  ////////////////////////////////////////////////////////////////////////////
  // lock-loss counter
  ////////////////////////////////////////////////////////////////////////////

  // one count per unlocked cycle and wraps at 2**diag_width
  always_ff @(posedge clk_125_0) begin
    if (!rstn_125_0) begin
      lock_loss_cnt_o <= '0;
    end else if (lock_lost) begin
      lock_loss_cnt_o <= lock_loss_cnt_o + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // a period of 1 would leave the counter with nothing to count
  a_period_min: assert property (
    @(posedge clk_125_0) blink_period_cycles >= 2
  ) else $error("monitor: blink_period_cycles must be at least 2");

  // blink only moves right after the heartbeat counter hit its end
  a_blink_on_wrap: assert property (
    @(posedge clk_125_0) disable iff (!rstn_125_0)
    ($past(rstn_125_0) && (blink_o != $past(blink_o))) |-> $past(hb_wrap)
  ) else $error("monitor: blink toggled off the heartbeat wrap");

  // counter steps by at most one even at the wrap
  a_loss_step: assert property (
    @(posedge clk_125_0) disable iff (!rstn_125_0)
    $past(rstn_125_0)
      |-> ((lock_loss_cnt_o == $past(lock_loss_cnt_o)) ||
           (lock_loss_cnt_o == $past(lock_loss_cnt_o) + 1'b1))
  ) else $error("monitor: lock-loss counter stepped by more than one");

  // an unlock seen at the pins shows up in the counter two edges later
  a_loss_latency: assert property (
    @(posedge clk_125_0) disable iff (!rstn_125_0)
    ($past(rstn_125_0, 1) && $past(rstn_125_0, 2) && $past(rstn_125_0, 3) &&
     !(&$past(pll_locked_i, 3)))
      |-> (lock_loss_cnt_o == $past(lock_loss_cnt_o) + 1'b1)
  ) else $error("monitor: unlocked cycle was not counted");

endmodule

// ==== source/adc_lane_capture.sv ====
`timescale 1ns/1ps

// one adc channel
// pins arrive as two 7-bit halves, one per clock edge
// rebuild the 14-bit code, convert to two's complement, register twice

module adc_lane_capture import adc_frontend_pkg::*; (
  input  logic                        clk_125_0,  // adc sample clock
  input  logic                        rstn_125_0, // sync, active low
  input  logic [pins_per_channel-1:0] adc_fall_i, // bits caught on falling edge
  input  logic [pins_per_channel-1:0] adc_rise_i, // bits caught on rising edge
  output adc_sample_t                 adc_dat_o   // converted sample, 2 cycle latency
);

  ////////////////////////////////////////////////////////////////////////////
  // bit interleave
  ////////////////////////////////////////////////////////////////////////////

  logic [sample_width-1:0] adc_raw;   // code as the adc sent it
  adc_sample_t             adc_conv;  // after code conversion
  adc_sample_t             adc_dat_r; // first pipeline stage

  // falling edge carries the even bits, rising edge the odd ones
  always_comb begin
    for (int k = 0; k < pins_per_channel; k++) begin
      adc_raw[2*k]   = adc_fall_i[k];
      adc_raw[2*k+1] = adc_rise_i[k];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // code conversion
  ////////////////////////////////////////////////////////////////////////////

  // adc delivers inverted magnitude below the msb
  // keep msb, flip the rest -> two's complement
  assign adc_conv = {adc_raw[sample_width-1], ~adc_raw[sample_width-2:0]};

  ////////////////////////////////////////////////////////////////////////////
  // two-stage pipeline
  ////////////////////////////////////////////////////////////////////////////

  // stage 1, catch the converted code
  always_ff @(posedge clk_125_0) begin
    if (!rstn_125_0) begin
      adc_dat_r <= '0;
    end else begin
      adc_dat_r <= adc_conv;
    end
  end

  // stage 2, drives the output directly
  always_ff @(posedge clk_125_0) begin
    if (!rstn_125_0) begin
      adc_dat_o <= '0;
    end else begin
      adc_dat_o <= adc_dat_r; // new sample every cycle, no stall
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // sign bit comes straight from rise pin 6, two edges back
  // covers interleave order and the msb pass-through in one go
  a_sign_from_rise_msb: assert property (
    @(posedge clk_125_0) disable iff (!rstn_125_0)
    ($past(rstn_125_0, 1) && $past(rstn_125_0, 2))
      |-> (adc_dat_o[sample_width-1] == $past(adc_rise_i[pins_per_channel-1], 2))
  ) else $error("lane: sign bit does not follow rise pin %0d", pins_per_channel-1);

  // lsb is the inverted fall pin 0, same latency
  a_lsb_from_fall: assert property (
    @(posedge clk_125_0) disable iff (!rstn_125_0)
    ($past(rstn_125_0, 1) && $past(rstn_125_0, 2))
      |-> (adc_dat_o[0] == ~$past(adc_fall_i[0], 2))
  ) else $error("lane: lsb does not follow inverted fall pin 0");

endmodule

// ==== source/adc_frontend_pkg.sv ====
package adc_frontend_pkg;

  //////////////////////////////////////////////////////////////////////////
  // adc geometry
  //////////////////////////////////////////////////////////////////////////

  // four fast channels, all on the 125 MHz clock
  localparam int num_channels = 4;

  // ddr pins per channel, one bit caught on each clock edge
  localparam int pins_per_channel = 7;

  // one full sample is both edges put together
  localparam int sample_width = 2 * pins_per_channel;

  // converted sample, two's complement
  typedef logic signed [sample_width-1:0] adc_sample_t;

  //////////////////////////////////////////////////////////////////////////
  // status and diagnostics
  //////////////////////////////////////////////////////////////////////////

  // lock-loss counter width, wraps silently
  localparam int diag_width = 32;

  // pll lock flags being watched
  localparam int num_plls = 2;

  // board led word
  localparam int led_width = 8;

  // heartbeat toggle interval in clk_125_0 cycles
  // 62.5M cycles at 125 MHz -> 0.5 s per toggle, 1 Hz blink
  localparam int default_blink_period = 62_500_000;

endpackage
